/* common/periph_pkg.sv */
/*
 * Peripheral subsystem address map, register offsets,
 * interrupt source layout and shared enums
 */
package periph_pkg;

  // Peripheral select field of the register address
  localparam int SEL_ADDR_MSB = 15;
  localparam int SEL_ADDR_LSB = 12;
  localparam int REG_ADDR_W   = 12;

  localparam logic [31:0] UNMAPPED_RDATA = 32'hBADC_AB1E;

  typedef enum logic [2:0] {
    SEL_SOC_CTRL,
    SEL_GPIO,
    SEL_TIMER,
    SEL_IRQ,
    SEL_NONE
  } periph_sel_e;

  // SoC control
  localparam logic [REG_ADDR_W-1:0] SOC_EXIT_VALID = 12'h000;
  localparam logic [REG_ADDR_W-1:0] SOC_EXIT_VALUE = 12'h004;
  localparam logic [REG_ADDR_W-1:0] SOC_SCRATCH    = 12'h008;

  // GPIO
  localparam logic [REG_ADDR_W-1:0] GPIO_IN          = 12'h000;
  localparam logic [REG_ADDR_W-1:0] GPIO_OUT         = 12'h004;
  localparam logic [REG_ADDR_W-1:0] GPIO_EN          = 12'h008;
  localparam logic [REG_ADDR_W-1:0] GPIO_INTR_EN     = 12'h00C;
  localparam logic [REG_ADDR_W-1:0] GPIO_INTR_STATUS = 12'h010;

  // Timer
  localparam logic [REG_ADDR_W-1:0] TMR_CTRL     = 12'h000;
  localparam logic [REG_ADDR_W-1:0] TMR_PRESCALE = 12'h004;
  localparam logic [REG_ADDR_W-1:0] TMR_COUNT    = 12'h008;
  localparam logic [REG_ADDR_W-1:0] TMR_COMPARE  = 12'h00C;

  // Interrupt controller
  localparam logic [REG_ADDR_W-1:0] IRQ_PENDING = 12'h000;
  localparam logic [REG_ADDR_W-1:0] IRQ_ENABLE  = 12'h004;
  localparam logic [REG_ADDR_W-1:0] IRQ_CLAIM   = 12'h008;
  localparam logic [REG_ADDR_W-1:0] IRQ_MSIP    = 12'h00C;

  // Source 0 is reserved and always zero
  localparam int NUM_IRQ_SRC   = 16;
  localparam int IRQ_ID_W      = 4;
  localparam int IRQ_GPIO_BASE = 1;
  localparam int IRQ_EXT_BASE  = 9;

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_ACCESS,
    BR_RESP
  } bridge_state_e;

endpackage : periph_pkg

/* compile.f */
common/periph_pkg.sv
src/periph_obi_bridge.sv
src/periph_reg_demux.sv
src/soc_ctrl.sv
gpio/gpio.sv
timer/rv_timer.sv
plic/irq_ctrl.sv
src/peripheral_subsystem.sv
sim/tb_clk_gen.sv
sim/tb_peripheral_subsystem.sv

/* gpio/gpio.sv */
/*
 * GPIO output, output enable and synchronized input registers,
 * rising-edge interrupt status on pins 0 to 7
 */
`timescale 1ns/1ps

module gpio (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              valid_i,
  input  logic                              write_i,
  input  logic [periph_pkg::REG_ADDR_W-1:0] addr_i,
  input  logic [31:0]                       wdata_i,
  output logic [31:0]                       rdata_o,
  input  logic [31:0]                       gpio_i,
  output logic [31:0]                       gpio_o,
  output logic [31:0]                       gpio_en_o,
  output logic [7:0]                        intr_o
);

  import periph_pkg::*;

  logic [31:0] sync_q1;
  logic [31:0] sync_q2;
  logic [7:0]  prev_q;
  logic [31:0] out_q;
  logic [31:0] en_q;
  logic [7:0]  intr_en_q;
  logic [7:0]  status_q;
  logic [7:0]  rise;
  logic [7:0]  status_clr;

  assign rise = sync_q2[7:0] & ~prev_q;

  // Write one to clear
  assign status_clr = (valid_i && write_i && addr_i == GPIO_INTR_STATUS) ? wdata_i[7:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1   <= '0;
      sync_q2   <= '0;
      prev_q    <= '0;
      out_q     <= '0;
      en_q      <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
    end else begin
      sync_q1  <= gpio_i;
      sync_q2  <= sync_q1;
      prev_q   <= sync_q2[7:0];
      // A new edge wins over a clear in the same cycle
      status_q <= (status_q & ~status_clr) | rise;
      if (valid_i && write_i) begin
        case (addr_i)
          GPIO_OUT:     out_q     <= wdata_i;
          GPIO_EN:      en_q      <= wdata_i;
          GPIO_INTR_EN: intr_en_q <= wdata_i[7:0];
          default:      ;
        endcase
      end
    end
  end

  always_comb begin
    case (addr_i)
      GPIO_IN:          rdata_o = sync_q2;
      GPIO_OUT:         rdata_o = out_q;
      GPIO_EN:          rdata_o = en_q;
      GPIO_INTR_EN:     rdata_o = {24'b0, intr_en_q};
      GPIO_INTR_STATUS: rdata_o = {24'b0, status_q};
      default:          rdata_o = '0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_en_o = en_q;
  assign intr_o    = status_q & intr_en_q;

endmodule : gpio

/* plic/irq_ctrl.sv */
/*
 * Interrupt controller with pending, enable, claim and MSIP registers
 */
`timescale 1ns/1ps

module irq_ctrl (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic                               valid_i,
  input  logic                               write_i,
  input  logic [periph_pkg::REG_ADDR_W-1:0]  addr_i,
  input  logic [31:0]                        wdata_i,
  output logic [31:0]                        rdata_o,
  input  logic [periph_pkg::NUM_IRQ_SRC-1:0] irq_src_i,
  output logic                               irq_o,
  output logic                               msip_o
);

  import periph_pkg::*;

  logic [NUM_IRQ_SRC-1:0] pending_q;
  logic [NUM_IRQ_SRC-1:0] enable_q;
  logic [NUM_IRQ_SRC-1:0] claimed_q;
  logic [NUM_IRQ_SRC-1:0] active;
  logic [NUM_IRQ_SRC-1:0] clr_mask;
  logic [IRQ_ID_W-1:0]    claim_id;
  logic                   claim_rd;
  logic                   msip_q;

  assign active   = pending_q & enable_q;
  assign claim_rd = valid_i && !write_i && (addr_i == IRQ_CLAIM);

  // Lowest ID wins, ID 0 means nothing to claim
  always_comb begin
    claim_id = '0;
    for (int i = NUM_IRQ_SRC - 1; i > 0; i--) begin
      if (active[i]) claim_id = IRQ_ID_W'(i);
    end
  end

  always_comb begin
    clr_mask = '0;
    if (claim_rd) clr_mask[claim_id] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
      claimed_q <= '0;
      msip_q    <= 1'b0;
    end else begin
      // A claimed source stays blocked until its line drops
      pending_q <= (pending_q & ~clr_mask) | (irq_src_i & ~claimed_q & ~clr_mask);
      claimed_q <= (claimed_q | clr_mask) & irq_src_i;
      if (valid_i && write_i && addr_i == IRQ_ENABLE) enable_q <= wdata_i[NUM_IRQ_SRC-1:0];
      if (valid_i && write_i && addr_i == IRQ_MSIP)   msip_q   <= wdata_i[0];
    end
  end

  always_comb begin
    case (addr_i)
      IRQ_PENDING: rdata_o = 32'(pending_q);
      IRQ_ENABLE:  rdata_o = 32'(enable_q);
      IRQ_CLAIM:   rdata_o = 32'(claim_id);
      IRQ_MSIP:    rdata_o = {31'b0, msip_q};
      default:     rdata_o = '0;
    endcase
  end

  assign irq_o  = |active;
  assign msip_o = msip_q;

endmodule : irq_ctrl

/* run.sh */
#!/usr/bin/env bash
# Build and run the peripheral subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_peripheral_subsystem -f compile.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log 2>/dev/null \
  && echo "run.sh: test run passed" \
  || { echo "run.sh: test run failed, see sim.log"; exit 1; }

/* sim/tb_clk_gen.sv */
/*
 * Free-running testbench clock
 */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule : tb_clk_gen

/* sim/tb_peripheral_subsystem.sv */
/*
 * Directed testbench for the peripheral subsystem: OBI access tasks,
 * value checker, xorshift data source and cycle watchdog
 */
`timescale 1ns/1ps

module tb_peripheral_subsystem;

  import periph_pkg::*;

  localparam int DRIVE_DLY    = 2;
  localparam int RESET_CYCLES = 16;
  // Roughly 50 accesses of 4 cycles plus timer and GPIO waits, with a wide margin
  localparam int MAX_CYCLES   = 4000;
  localparam int GNT_TIMEOUT  = 16;
  localparam int TIMER_LIMIT  = 60;

  // Peripheral regions in address bits 15:12
  localparam logic [3:0] SOC_REGION  = 4'd0;
  localparam logic [3:0] GPIO_REGION = 4'd1;
  localparam logic [3:0] TMR_REGION  = 4'd2;
  localparam logic [3:0] IRQ_REGION  = 4'd3;
  localparam logic [3:0] FREE_REGION = 4'd7;

  // GPIO pin 3 and external line 1
  localparam int GPIO_PIN3_ID  = 4;
  localparam int EXT_LINE1_ID  = 10;
  localparam logic [31:0] TIMER_COMPARE = 32'd20;

  logic        clk;
  logic        arst_n;
  logic        obi_req;
  logic        obi_we;
  logic [31:0] obi_addr;
  logic [31:0] obi_wdata;
  logic        obi_gnt;
  logic        obi_rvalid;
  logic [31:0] obi_rdata;
  logic        exit_valid;
  logic [31:0] exit_value;
  logic [31:0] gpio_in;
  logic [31:0] gpio_out;
  logic [31:0] gpio_en;
  logic        timer_irq;
  logic [3:0]  intr_ext;
  logic        irq;
  logic        msip;
  logic [31:0] rng_state;
  int          cycle_cnt = 0;

  tb_clk_gen #(.PERIOD_NS(40)) clk_gen_i (.clk_o(clk));

  peripheral_subsystem #(
    .EXT_NINTERRUPT(4)
  ) dut_i (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .obi_req_i        (obi_req),
    .obi_we_i         (obi_we),
    .obi_addr_i       (obi_addr),
    .obi_wdata_i      (obi_wdata),
    .obi_gnt_o        (obi_gnt),
    .obi_rvalid_o     (obi_rvalid),
    .obi_rdata_o      (obi_rdata),
    .exit_valid_o     (exit_valid),
    .exit_value_o     (exit_value),
    .gpio_i           (gpio_in),
    .gpio_o           (gpio_out),
    .gpio_en_o        (gpio_en),
    .timer_irq_o      (timer_irq),
    .intr_vector_ext_i(intr_ext),
    .irq_o            (irq),
    .msip_o           (msip)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] periph_addr(input logic [3:0] region,
                                              input logic [11:0] offset);
    return {16'h0000, region, offset};
  endfunction

  task automatic next_random(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value = rng_state;
  endtask

  task automatic stop_on_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped on first failure");
  endtask

  task automatic check_eq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] t=%0t %s: expected 0x%08h, actual 0x%08h",
               $time, name, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Starts and ends DRIVE_DLY after a rising edge
  task automatic obi_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited    = 0;
    obi_req   = 1'b1;
    obi_we    = we;
    obi_addr  = addr;
    obi_wdata = wdata;
    @(negedge clk);
    while (!obi_gnt) begin
      waited++;
      if (waited > GNT_TIMEOUT) begin
        $display("No grant within %0d cycles for address 0x%08h", GNT_TIMEOUT, addr);
        stop_on_failure();
      end
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DLY;
    obi_req = 1'b0;
    obi_we  = 1'b0;
    // rvalid exactly two cycles after the grant cycle
    @(negedge clk);
    check_eq("obi_rvalid_o", 32'(obi_rvalid), 32'd0);
    @(negedge clk);
    check_eq("obi_rvalid_o", 32'(obi_rvalid), 32'd1);
    rdata = obi_rdata;
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic obi_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    obi_access(1'b1, addr, wdata, rdata);
    check_eq("obi_rdata_o on write", rdata, 32'd0);
  endtask

  task automatic obi_read(input logic [31:0] addr, output logic [31:0] rdata);
    obi_access(1'b0, addr, 32'd0, rdata);
  endtask

  task automatic read_expect(input string name, input logic [31:0] addr,
                             input logic [31:0] expected);
    logic [31:0] rdata;
    obi_read(addr, rdata);
    check_eq(name, rdata, expected);
  endtask

  task automatic reset_and_unmapped();
    check_eq("obi_gnt_o", 32'(obi_gnt), 32'd0);
    check_eq("obi_rvalid_o", 32'(obi_rvalid), 32'd0);
    check_eq("exit_valid_o", 32'(exit_valid), 32'd0);
    check_eq("gpio_o", gpio_out, 32'd0);
    check_eq("gpio_en_o", gpio_en, 32'd0);
    check_eq("timer_irq_o", 32'(timer_irq), 32'd0);
    check_eq("irq_o", 32'(irq), 32'd0);
    check_eq("msip_o", 32'(msip), 32'd0);
    read_expect("GPIO_OUT", periph_addr(GPIO_REGION, GPIO_OUT), 32'd0);
    read_expect("IRQ_ENABLE", periph_addr(IRQ_REGION, IRQ_ENABLE), 32'd0);
    read_expect("unmapped read", periph_addr(FREE_REGION, 12'h000), UNMAPPED_RDATA);
    obi_write(periph_addr(FREE_REGION, 12'h000), 32'h1234_5678);
  endtask

  task automatic soc_ctrl_regs();
    logic [31:0] scratch;
    logic [31:0] value;
    next_random(scratch);
    next_random(value);
    obi_write(periph_addr(SOC_REGION, SOC_SCRATCH), scratch);
    read_expect("SOC_SCRATCH", periph_addr(SOC_REGION, SOC_SCRATCH), scratch);
    obi_write(periph_addr(SOC_REGION, SOC_EXIT_VALUE), value);
    read_expect("SOC_EXIT_VALUE", periph_addr(SOC_REGION, SOC_EXIT_VALUE), value);
    check_eq("exit_value_o", exit_value, value);
    check_eq("exit_valid_o", 32'(exit_valid), 32'd0);
    obi_write(periph_addr(SOC_REGION, SOC_EXIT_VALID), 32'd1);
    check_eq("exit_valid_o", 32'(exit_valid), 32'd1);
    read_expect("SOC_EXIT_VALID", periph_addr(SOC_REGION, SOC_EXIT_VALID), 32'd1);
  endtask

  task automatic gpio_out_and_in();
    logic [31:0] out_val;
    logic [31:0] en_val;
    logic [31:0] in_val;
    next_random(out_val);
    next_random(en_val);
    next_random(in_val);
    obi_write(periph_addr(GPIO_REGION, GPIO_OUT), out_val);
    check_eq("gpio_o", gpio_out, out_val);
    obi_write(periph_addr(GPIO_REGION, GPIO_EN), en_val);
    check_eq("gpio_en_o", gpio_en, en_val);
    read_expect("GPIO_OUT", periph_addr(GPIO_REGION, GPIO_OUT), out_val);
    read_expect("GPIO_EN", periph_addr(GPIO_REGION, GPIO_EN), en_val);
    gpio_in = in_val;
    wait_cycles(3);
    read_expect("GPIO_IN", periph_addr(GPIO_REGION, GPIO_IN), in_val);
  endtask

  task automatic gpio_edge_status();
    gpio_in = 32'd0;
    wait_cycles(4);
    obi_write(periph_addr(GPIO_REGION, GPIO_INTR_STATUS), 32'h0000_00FF);
    read_expect("GPIO_INTR_STATUS", periph_addr(GPIO_REGION, GPIO_INTR_STATUS), 32'd0);
    gpio_in[3] = 1'b1;
    wait_cycles(4);
    read_expect("GPIO_INTR_STATUS", periph_addr(GPIO_REGION, GPIO_INTR_STATUS),
                32'd1 << 3);
    obi_write(periph_addr(GPIO_REGION, GPIO_INTR_STATUS), 32'd1 << 3);
    read_expect("GPIO_INTR_STATUS", periph_addr(GPIO_REGION, GPIO_INTR_STATUS), 32'd0);
  endtask

  task automatic timer_compare();
    logic [31:0] count;
    logic        irq_before;
    int          start;
    obi_write(periph_addr(TMR_REGION, TMR_PRESCALE), 32'd1);
    obi_write(periph_addr(TMR_REGION, TMR_COMPARE), TIMER_COMPARE);
    check_eq("timer_irq_o", 32'(timer_irq), 32'd0);
    obi_write(periph_addr(TMR_REGION, TMR_CTRL), 32'd1);
    start = cycle_cnt;
    // Count only rises, so a low read means the earlier sample was below compare
    do begin
      irq_before = timer_irq;
      obi_read(periph_addr(TMR_REGION, TMR_COUNT), count);
      if (count < TIMER_COMPARE) check_eq("timer_irq_o", 32'(irq_before), 32'd0);
    end while (count < TIMER_COMPARE && cycle_cnt - start <= TIMER_LIMIT);
    if (cycle_cnt - start > TIMER_LIMIT) begin
      $display("Timer count did not reach compare within %0d cycles", TIMER_LIMIT);
      stop_on_failure();
    end
    check_eq("timer_irq_o", 32'(timer_irq), 32'd1);
    obi_write(periph_addr(TMR_REGION, TMR_CTRL), 32'd0);
    check_eq("timer_irq_o", 32'(timer_irq), 32'd0);
  endtask

  task automatic irq_claim();
    logic [31:0] id_mask;
    id_mask = (32'd1 << GPIO_PIN3_ID) | (32'd1 << EXT_LINE1_ID);
    gpio_in = 32'd0;
    wait_cycles(4);
    obi_write(periph_addr(GPIO_REGION, GPIO_INTR_STATUS), 32'h0000_00FF);
    obi_write(periph_addr(GPIO_REGION, GPIO_INTR_EN), 32'd1 << 3);
    obi_write(periph_addr(IRQ_REGION, IRQ_ENABLE), id_mask);
    check_eq("irq_o", 32'(irq), 32'd0);
    intr_ext = 4'b0010;
    wait_cycles(1);
    intr_ext = 4'b0000;
    gpio_in[3] = 1'b1;
    wait_cycles(5);
    check_eq("irq_o", 32'(irq), 32'd1);
    read_expect("IRQ_PENDING", periph_addr(IRQ_REGION, IRQ_PENDING), id_mask);
    read_expect("IRQ_CLAIM", periph_addr(IRQ_REGION, IRQ_CLAIM), GPIO_PIN3_ID);
    check_eq("irq_o", 32'(irq), 32'd1);
    read_expect("IRQ_CLAIM", periph_addr(IRQ_REGION, IRQ_CLAIM), EXT_LINE1_ID);
    check_eq("irq_o", 32'(irq), 32'd0);
    read_expect("IRQ_CLAIM", periph_addr(IRQ_REGION, IRQ_CLAIM), 32'd0);
    obi_write(periph_addr(IRQ_REGION, IRQ_MSIP), 32'd1);
    check_eq("msip_o", 32'(msip), 32'd1);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      stop_on_failure();
    end
  end

  initial begin
    rng_state = 32'd79;
    arst_n    = 1'b0;
    obi_req   = 1'b0;
    obi_we    = 1'b0;
    obi_addr  = 32'd0;
    obi_wdata = 32'd0;
    gpio_in   = 32'd0;
    intr_ext  = 4'b0000;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;

    reset_and_unmapped();
    soc_ctrl_regs();
    gpio_out_and_in();
    gpio_edge_status();
    timer_compare();
    irq_claim();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule : tb_peripheral_subsystem

/* src/periph_obi_bridge.sv */
/*
 * OBI slave port to register bus bridge, fixed two-cycle response
 */
`timescale 1ns/1ps

module periph_obi_bridge (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        obi_req_i,
  input  logic        obi_we_i,
  input  logic [31:0] obi_addr_i,
  input  logic [31:0] obi_wdata_i,
  output logic        obi_gnt_o,
  output logic        obi_rvalid_o,
  output logic [31:0] obi_rdata_o,
  output logic        reg_valid_o,
  output logic        reg_write_o,
  output logic [15:0] reg_addr_o,
  output logic [31:0] reg_wdata_o,
  input  logic [31:0] reg_rdata_i
);

  import periph_pkg::*;

  bridge_state_e state_q;
  bridge_state_e state_d;

  logic        we_q;
  logic [15:0] addr_q;
  logic [31:0] wdata_q;
  logic [31:0] rdata_q;

  // Only one transaction in flight
  assign obi_gnt_o = obi_req_i && (state_q == BR_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      BR_IDLE:   if (obi_gnt_o) state_d = BR_ACCESS;
      BR_ACCESS: state_d = BR_RESP;
      BR_RESP:   state_d = BR_IDLE;
      default:   state_d = BR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (obi_gnt_o) begin
      we_q    <= obi_we_i;
      addr_q  <= obi_addr_i[15:0];
      wdata_q <= obi_wdata_i;
    end
    // Writes answer with zero data
    if (state_q == BR_ACCESS) begin
      rdata_q <= we_q ? '0 : reg_rdata_i;
    end
  end

  assign reg_valid_o  = (state_q == BR_ACCESS);
  assign reg_write_o  = we_q;
  assign reg_addr_o   = addr_q;
  assign reg_wdata_o  = wdata_q;

  assign obi_rvalid_o = (state_q == BR_RESP);
  assign obi_rdata_o  = rdata_q;

endmodule : periph_obi_bridge

/* src/periph_reg_demux.sv */
/*
 * Register bus decoder, strobe steering and read data return mux
 */
`timescale 1ns/1ps

module periph_reg_demux (
  input  logic                            reg_valid_i,
  input  logic                            reg_write_i,
  input  logic [15:0]                     reg_addr_i,
  input  logic [31:0]                     reg_wdata_i,
  output logic [31:0]                     reg_rdata_o,
  output logic                            soc_valid_o,
  output logic                            gpio_valid_o,
  output logic                            tmr_valid_o,
  output logic                            irq_valid_o,
  output logic                            per_write_o,
  output logic [periph_pkg::REG_ADDR_W-1:0] per_addr_o,
  output logic [31:0]                     per_wdata_o,
  input  logic [31:0]                     soc_rdata_i,
  input  logic [31:0]                     gpio_rdata_i,
  input  logic [31:0]                     tmr_rdata_i,
  input  logic [31:0]                     irq_rdata_i
);

  import periph_pkg::*;

  periph_sel_e sel;

  always_comb begin
    case (reg_addr_i[SEL_ADDR_MSB:SEL_ADDR_LSB])
      4'd0:    sel = SEL_SOC_CTRL;
      4'd1:    sel = SEL_GPIO;
      4'd2:    sel = SEL_TIMER;
      4'd3:    sel = SEL_IRQ;
      default: sel = SEL_NONE;
    endcase
  end

  assign soc_valid_o  = reg_valid_i && (sel == SEL_SOC_CTRL);
  assign gpio_valid_o = reg_valid_i && (sel == SEL_GPIO);
  assign tmr_valid_o  = reg_valid_i && (sel == SEL_TIMER);
  assign irq_valid_o  = reg_valid_i && (sel == SEL_IRQ);

  // Shared by all peripherals
  assign per_write_o = reg_write_i;
  assign per_addr_o  = reg_addr_i[REG_ADDR_W-1:0];
  assign per_wdata_o = reg_wdata_i;

  always_comb begin
    case (sel)
      SEL_SOC_CTRL: reg_rdata_o = soc_rdata_i;
      SEL_GPIO:     reg_rdata_o = gpio_rdata_i;
      SEL_TIMER:    reg_rdata_o = tmr_rdata_i;
      SEL_IRQ:      reg_rdata_o = irq_rdata_i;
      default:      reg_rdata_o = UNMAPPED_RDATA;
    endcase
  end

endmodule : periph_reg_demux

/* src/peripheral_subsystem.sv */
/*
 * Peripheral subsystem top: OBI bridge, register demux, SoC control,
 * GPIO, timer and interrupt controller
 */
`timescale 1ns/1ps

module peripheral_subsystem #(
  parameter int EXT_NINTERRUPT = 0
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      obi_req_i,
  input  logic                      obi_we_i,
  input  logic [31:0]               obi_addr_i,
  input  logic [31:0]               obi_wdata_i,
  output logic                      obi_gnt_o,
  output logic                      obi_rvalid_o,
  output logic [31:0]               obi_rdata_o,
  output logic                      exit_valid_o,
  output logic [31:0]               exit_value_o,
  input  logic [31:0]               gpio_i,
  output logic [31:0]               gpio_o,
  output logic [31:0]               gpio_en_o,
  output logic                      timer_irq_o,
  input  logic [EXT_NINTERRUPT-1:0] intr_vector_ext_i,
  output logic                      irq_o,
  output logic                      msip_o
);

  import periph_pkg::*;

  logic                   reg_valid;
  logic                   reg_write;
  logic [15:0]            reg_addr;
  logic [31:0]            reg_wdata;
  logic [31:0]            reg_rdata;
  logic                   soc_valid;
  logic                   gpio_valid;
  logic                   tmr_valid;
  logic                   irq_valid;
  logic                   per_write;
  logic [REG_ADDR_W-1:0]  per_addr;
  logic [31:0]            per_wdata;
  logic [31:0]            soc_rdata;
  logic [31:0]            gpio_rdata;
  logic [31:0]            tmr_rdata;
  logic [31:0]            irq_rdata;
  logic [7:0]             gpio_intr;
  logic [NUM_IRQ_SRC-1:0] irq_src;

  // Source 0 and unused IDs stay zero
  always_comb begin
    irq_src = '0;
    irq_src[IRQ_GPIO_BASE +: 8] = gpio_intr;
    for (int i = 0; i < EXT_NINTERRUPT; i++) begin
      irq_src[IRQ_EXT_BASE + i] = intr_vector_ext_i[i];
    end
  end

  periph_obi_bridge periph_obi_bridge_i (
    .clk_i,
    .arst_n_i,
    .obi_req_i,
    .obi_we_i,
    .obi_addr_i,
    .obi_wdata_i,
    .obi_gnt_o,
    .obi_rvalid_o,
    .obi_rdata_o,
    .reg_valid_o(reg_valid),
    .reg_write_o(reg_write),
    .reg_addr_o (reg_addr),
    .reg_wdata_o(reg_wdata),
    .reg_rdata_i(reg_rdata)
  );

  periph_reg_demux periph_reg_demux_i (
    .reg_valid_i (reg_valid),
    .reg_write_i (reg_write),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .soc_valid_o (soc_valid),
    .gpio_valid_o(gpio_valid),
    .tmr_valid_o (tmr_valid),
    .irq_valid_o (irq_valid),
    .per_write_o (per_write),
    .per_addr_o  (per_addr),
    .per_wdata_o (per_wdata),
    .soc_rdata_i (soc_rdata),
    .gpio_rdata_i(gpio_rdata),
    .tmr_rdata_i (tmr_rdata),
    .irq_rdata_i (irq_rdata)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .arst_n_i,
    .valid_i(soc_valid),
    .write_i(per_write),
    .addr_i (per_addr),
    .wdata_i(per_wdata),
    .rdata_o(soc_rdata),
    .exit_valid_o,
    .exit_value_o
  );

  gpio gpio_block_i (
    .clk_i,
    .arst_n_i,
    .valid_i(gpio_valid),
    .write_i(per_write),
    .addr_i (per_addr),
    .wdata_i(per_wdata),
    .rdata_o(gpio_rdata),
    .gpio_i,
    .gpio_o,
    .gpio_en_o,
    .intr_o (gpio_intr)
  );

  rv_timer rv_timer_i (
    .clk_i,
    .arst_n_i,
    .valid_i(tmr_valid),
    .write_i(per_write),
    .addr_i (per_addr),
    .wdata_i(per_wdata),
    .rdata_o(tmr_rdata),
    .timer_irq_o
  );

  irq_ctrl irq_ctrl_i (
    .clk_i,
    .arst_n_i,
    .valid_i  (irq_valid),
    .write_i  (per_write),
    .addr_i   (per_addr),
    .wdata_i  (per_wdata),
    .rdata_o  (irq_rdata),
    .irq_src_i(irq_src),
    .irq_o,
    .msip_o
  );

endmodule : peripheral_subsystem

/* src/soc_ctrl.sv */
/*
 * SoC control registers, simulation exit strobe and scratch word
 */
`timescale 1ns/1ps

module soc_ctrl (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              valid_i,
  input  logic                              write_i,
  input  logic [periph_pkg::REG_ADDR_W-1:0] addr_i,
  input  logic [31:0]                       wdata_i,
  output logic [31:0]                       rdata_o,
  output logic                              exit_valid_o,
  output logic [31:0]                       exit_value_o
);

  import periph_pkg::*;

  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic [31:0] scratch_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q    <= '0;
    end else if (valid_i && write_i) begin
      case (addr_i)
        SOC_EXIT_VALID: exit_valid_q <= wdata_i[0];
        SOC_EXIT_VALUE: exit_value_q <= wdata_i;
        SOC_SCRATCH:    scratch_q    <= wdata_i;
        default:        ;
      endcase
    end
  end

  always_comb begin
    case (addr_i)
      SOC_EXIT_VALID: rdata_o = {31'b0, exit_valid_q};
      SOC_EXIT_VALUE: rdata_o = exit_value_q;
      SOC_SCRATCH:    rdata_o = scratch_q;
      default:        rdata_o = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl

/* timer/rv_timer.sv */
/*
 * Prescaled up-counter with compare interrupt
 */
`timescale 1ns/1ps

module rv_timer (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              valid_i,
  input  logic                              write_i,
  input  logic [periph_pkg::REG_ADDR_W-1:0] addr_i,
  input  logic [31:0]                       wdata_i,
  output logic [31:0]                       rdata_o,
  output logic                              timer_irq_o
);

  import periph_pkg::*;

  logic        en_q;
  logic [31:0] prescale_q;
  logic [31:0] presc_cnt_q;
  logic [31:0] count_q;
  logic [31:0] compare_q;
  logic        tick;
  logic        wr;

  assign wr   = valid_i && write_i;
  assign tick = en_q && (presc_cnt_q == prescale_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q        <= 1'b0;
      prescale_q  <= '0;
      presc_cnt_q <= '0;
      count_q     <= '0;
      compare_q   <= '0;
    end else begin
      // Prescaler idles at zero while disabled
      if (!en_q || tick) presc_cnt_q <= '0;
      else               presc_cnt_q <= presc_cnt_q + 32'd1;

      if (wr && addr_i == TMR_COUNT) count_q <= wdata_i;
      else if (tick)                 count_q <= count_q + 32'd1;

      if (wr && addr_i == TMR_CTRL)     en_q       <= wdata_i[0];
      if (wr && addr_i == TMR_PRESCALE) prescale_q <= wdata_i;
      if (wr && addr_i == TMR_COMPARE)  compare_q  <= wdata_i;
    end
  end

  always_comb begin
    case (addr_i)
      TMR_CTRL:     rdata_o = {31'b0, en_q};
      TMR_PRESCALE: rdata_o = prescale_q;
      TMR_COUNT:    rdata_o = count_q;
      TMR_COMPARE:  rdata_o = compare_q;
      default:      rdata_o = '0;
    endcase
  end

  assign timer_irq_o = en_q && (count_q >= compare_q);

endmodule : rv_timer
